// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache
SIM_F     ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(SIM_F)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(SIM_F) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/cache_wr_if.sv
`timescale 1ns/100ps
`default_nettype none

// one write into the tag and data RAMs of every way, shared index
interface cache_wr_if;

    logic [dcache_pkg::WAYS-1:0] tag_we;
    logic [dcache_pkg::WAYS-1:0] data_we;
    dcache_pkg::index_t          waddr;
    dcache_pkg::tag_t            tag_wdata;
    dcache_pkg::line_t           data_wdata;

    modport ctrl (output tag_we, data_we, waddr, tag_wdata, data_wdata);
    modport ram  (input  tag_we, data_we, waddr, tag_wdata, data_wdata);

endinterface

`default_nettype wire

// File: rtl/dcache_lookup.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_lookup (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    input  logic                     req_write,
    input  dcache_pkg::word_t        req_addr,
    input  dcache_pkg::word_t        req_wdata,
    input  logic [3:0]               req_byteen,
    input  dcache_pkg::load_kind_t   req_kind,
    input  logic                     stall,
    cache_wr_if.ram                  wr,
    output dcache_pkg::stage_entry_t entry
);

    typedef struct packed {
        logic                   valid;
        logic                   write;
        dcache_pkg::word_t      addr;
        dcache_pkg::word_t      wdata;
        logic [3:0]             byteen;
        dcache_pkg::load_kind_t kind;
    } req_t;

    req_t idx_q, cmp_q;     // index stage, compare stage
    dcache_pkg::index_t rd_index, cmp_index;
    dcache_pkg::tag_t  [dcache_pkg::WAYS-1:0] tag_q, tag_r;
    dcache_pkg::line_t [dcache_pkg::WAYS-1:0] line_q, line_r;
    logic [dcache_pkg::WAYS-1:0] fwd_tag_we, fwd_data_we, hit;
    dcache_pkg::tag_t  fwd_tag;
    dcache_pkg::line_t fwd_line;
    logic [dcache_pkg::SETS-1:0] lru;   // way that was used least recently
    logic all_valid, miss;
    dcache_pkg::way_t hit_way, victim, used_way;
    dcache_pkg::stage_entry_t entry_d;

    assign rd_index  = dcache_pkg::line_index(idx_q.addr);
    assign cmp_index = dcache_pkg::line_index(cmp_q.addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            idx_q.valid <= 1'b0;
            cmp_q.valid <= 1'b0;
        end else if (!stall) begin
            idx_q <= '{req_valid, req_write, req_addr, req_wdata, req_byteen, req_kind};
            cmp_q <= idx_q;
        end
    end

    for (genvar w = 0; w < dcache_pkg::WAYS; w++) begin : g_way
        sdp_ram #(.payload_t(dcache_pkg::tag_t), .DEPTH(dcache_pkg::SETS)) tag_ram (
            .clk(clk), .we(wr.tag_we[w]), .waddr(wr.waddr), .wdata(wr.tag_wdata),
            .ren(!stall), .raddr(rd_index), .rdata(tag_q[w])
        );
        sdp_ram #(.payload_t(dcache_pkg::line_t), .DEPTH(dcache_pkg::SETS)) data_ram (
            .clk(clk), .we(wr.data_we[w]), .waddr(wr.waddr), .wdata(wr.data_wdata),
            .ren(!stall), .raddr(rd_index), .rdata(line_q[w])
        );
    end

    // a write racing the RAM read is lost by the read-first port, keep it aside
    always_ff @(posedge clk) begin
        if (rst) begin
            fwd_tag_we  <= '0;
            fwd_data_we <= '0;
        end else if (!stall) begin
            fwd_tag_we  <= wr.tag_we & {dcache_pkg::WAYS{wr.waddr == rd_index}};
            fwd_data_we <= wr.data_we & {dcache_pkg::WAYS{wr.waddr == rd_index}};
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            fwd_tag  <= wr.tag_wdata;
            fwd_line <= wr.data_wdata;
        end
    end

    always_comb begin
        all_valid = 1'b1;
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            tag_r[w]  = fwd_tag_we[w] ? fwd_tag : tag_q[w];
            line_r[w] = fwd_data_we[w] ? fwd_line : line_q[w];
            if (wr.tag_we[w] && wr.waddr == cmp_index) tag_r[w] = wr.tag_wdata;
            if (wr.data_we[w] && wr.waddr == cmp_index) line_r[w] = wr.data_wdata;
            hit[w] = tag_r[w].valid && tag_r[w].tag == dcache_pkg::line_tag(cmp_q.addr);
            all_valid = all_valid & tag_r[w].valid;
        end
    end

    // lowest invalid way wins over the lru choice
    always_comb begin
        hit_way = '0;
        victim  = dcache_pkg::way_t'(lru[cmp_index]);
        for (int w = dcache_pkg::WAYS - 1; w >= 0; w--) begin
            if (hit[w]) hit_way = dcache_pkg::way_t'(w);
            if (!tag_r[w].valid) victim = dcache_pkg::way_t'(w);
        end
    end

    assign miss     = ~|hit;
    assign used_way = miss ? victim : hit_way;

    always_ff @(posedge clk) begin
        if (rst) begin
            lru <= '0;
        end else if (!stall && cmp_q.valid) begin
            lru[cmp_index] <= (used_way == '0);   // the other way becomes lru
        end
    end

    always_comb begin
        entry_d.valid       = cmp_q.valid;
        entry_d.write       = cmp_q.write;
        entry_d.addr        = cmp_q.addr;
        entry_d.wdata       = cmp_q.wdata;
        entry_d.byteen      = cmp_q.byteen;
        entry_d.kind        = cmp_q.kind;
        entry_d.miss        = miss;
        entry_d.hit_way     = hit_way;
        entry_d.victim_way  = victim;
        entry_d.need_wb     = tag_r[victim].dirty & all_valid;
        entry_d.hit_line    = line_r[hit_way];
        entry_d.victim_line = line_r[victim];
        entry_d.wb_addr     = {tag_r[victim].tag, cmp_index, {dcache_pkg::LINE_OFF_W{1'b0}}};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entry.valid <= 1'b0;
        end else if (!stall) begin
            entry <= entry_d;
        end
    end

    a_one_hit: assert property (@(posedge clk) disable iff (rst)
        cmp_q.valid |-> $onehot0(hit));

endmodule

`default_nettype wire

// File: rtl/dcache_miss_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_miss_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  dcache_pkg::stage_entry_t entry,
    input  dcache_pkg::line_t        merged_line,
    output logic                     ready,
    output logic                     stall,
    output dcache_pkg::line_t        refill_line,
    cache_wr_if.ctrl                 wr,
    output logic                     ar_valid,
    input  logic                     ar_ready,
    output dcache_pkg::word_t        ar_addr,
    input  logic                     r_valid,
    output logic                     r_ready,
    input  dcache_pkg::word_t        r_data,
    input  logic                     r_last,
    output logic                     aw_valid,
    input  logic                     aw_ready,
    output dcache_pkg::word_t        aw_addr,
    output logic                     w_valid,
    input  logic                     w_ready,
    output dcache_pkg::word_t        w_data,
    output logic                     w_last,
    input  logic                     b_valid
);

    typedef enum logic [2:0] {
        S_SWEEP,
        S_IDLE,
        S_WB_ADDR,
        S_WB_DATA,
        S_WB_RESP,
        S_RD_ADDR,
        S_RD_DATA,
        S_CACHE_WR
    } state_t;

    state_t state, state_d;
    dcache_pkg::index_t sweep_cnt;
    logic [dcache_pkg::WORD_OFF_W-1:0] beat_cnt;
    logic w_beat, r_beat;

    always_comb begin
        state_d = state;
        case (state)
            S_SWEEP:    if (sweep_cnt == dcache_pkg::index_t'(dcache_pkg::SETS - 1)) state_d = S_IDLE;
            S_IDLE: begin
                if (entry.valid && entry.miss) begin
                    state_d = entry.need_wb ? S_WB_ADDR : S_RD_ADDR;
                end
            end
            S_WB_ADDR:  if (aw_ready) state_d = S_WB_DATA;
            S_WB_DATA:  if (w_ready && w_last) state_d = S_WB_RESP;
            S_WB_RESP:  if (b_valid) state_d = S_RD_ADDR;
            S_RD_ADDR:  if (ar_ready) state_d = S_RD_DATA;
            S_RD_DATA:  if (r_valid && r_last) state_d = S_CACHE_WR;
            S_CACHE_WR: state_d = S_IDLE;
            default:    state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_SWEEP;
            sweep_cnt <= '0;
            beat_cnt  <= '0;
        end else begin
            state <= state_d;
            if (state == S_SWEEP) sweep_cnt <= sweep_cnt + 1'b1;
            if (state == S_IDLE) begin
                beat_cnt <= '0;
            end else if (w_beat || r_beat) begin
                beat_cnt <= beat_cnt + 1'b1;   // wraps back to zero after a burst
            end
        end
    end

    assign w_beat = w_valid && w_ready;
    assign r_beat = r_valid && r_ready;

    always_ff @(posedge clk) begin
        if (r_beat) begin
            refill_line[beat_cnt] <= r_data;
        end
    end

    // pipeline holds until the next idle cycle and for the whole sweep
    assign stall = (state_d != S_IDLE) || (state == S_SWEEP);
    assign ready = (state != S_SWEEP);

    assign aw_valid = (state == S_WB_ADDR);
    assign aw_addr  = entry.wb_addr;
    assign w_valid  = (state == S_WB_DATA);
    assign w_data   = entry.victim_line[beat_cnt];
    assign w_last   = w_valid && (beat_cnt == '1);
    assign ar_valid = (state == S_RD_ADDR);
    assign ar_addr  = {entry.addr[31:dcache_pkg::LINE_OFF_W], {dcache_pkg::LINE_OFF_W{1'b0}}};
    assign r_ready  = (state == S_RD_DATA);

    // the sweep writes invalid tags to every way of one set per cycle
    always_comb begin
        wr.tag_we  = '0;
        wr.data_we = '0;
        case (state)
            S_SWEEP: wr.tag_we = '1;
            S_IDLE: begin
                if (entry.valid && entry.write && !entry.miss) begin  // store hit
                    wr.tag_we[entry.hit_way]  = 1'b1;
                    wr.data_we[entry.hit_way] = 1'b1;
                end
            end
            S_CACHE_WR: begin
                wr.tag_we[entry.victim_way]  = 1'b1;
                wr.data_we[entry.victim_way] = 1'b1;
            end
            default: ;
        endcase
    end

    assign wr.waddr            = (state == S_SWEEP) ? sweep_cnt : dcache_pkg::line_index(entry.addr);
    assign wr.tag_wdata.valid  = (state != S_SWEEP);
    assign wr.tag_wdata.dirty  = entry.write;
    assign wr.tag_wdata.tag    = dcache_pkg::line_tag(entry.addr);
    assign wr.data_wdata       = merged_line;

    // the last read beat must land on the last word of the refill buffer
    a_rlast_on_fourth: assert property (@(posedge clk) disable iff (rst)
        r_beat |-> (r_last == (beat_cnt == '1)));
    a_addr_held: assert property (@(posedge clk) disable iff (rst)
        (ar_valid && !ar_ready) || (aw_valid && !aw_ready) |=>
            $stable(ar_addr) && $stable(aw_addr));

endmodule

`default_nettype wire

// File: rtl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int WAYS       = 2;
    localparam int SETS       = 8;
    localparam int LINE_WORDS = 4;

    localparam int WORD_OFF_W = $clog2(LINE_WORDS);
    localparam int INDEX_W    = $clog2(SETS);
    localparam int LINE_OFF_W = WORD_OFF_W + 2;   // byte offset inside a line
    localparam int TAG_W      = 32 - INDEX_W - LINE_OFF_W;
    localparam int WAY_W      = $clog2(WAYS);

    typedef logic [31:0] word_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [WAY_W-1:0] way_t;
    typedef word_t [LINE_WORDS-1:0] line_t;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } tag_t;

    typedef enum logic [2:0] {LW, LH, LHU, LB, LBU} load_kind_t;

    // request as it leaves the compare stage
    typedef struct packed {
        logic       valid;
        logic       write;
        word_t      addr;
        word_t      wdata;
        logic [3:0] byteen;
        load_kind_t kind;
        logic       miss;
        way_t       hit_way;
        way_t       victim_way;
        logic       need_wb;    // victim is dirty and the set is full
        line_t      hit_line;
        line_t      victim_line;
        word_t      wb_addr;
    } stage_entry_t;

    function automatic index_t line_index(input word_t addr);
        return addr[LINE_OFF_W +: INDEX_W];
    endfunction

    function automatic logic [TAG_W-1:0] line_tag(input word_t addr);
        return addr[31 -: TAG_W];
    endfunction

    function automatic logic [WORD_OFF_W-1:0] word_offset(input word_t addr);
        return addr[2 +: WORD_OFF_W];
    endfunction

endpackage

`default_nettype wire

// File: rtl/dcache_resp.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_resp (
    input  dcache_pkg::stage_entry_t entry,
    input  dcache_pkg::line_t        refill_line,
    input  logic                     stall,
    output dcache_pkg::line_t        merged_line,
    output logic                     resp_valid,
    output dcache_pkg::word_t        resp_rdata
);

    dcache_pkg::line_t base_line;
    logic [dcache_pkg::WORD_OFF_W-1:0] off;
    dcache_pkg::word_t aligned;

    assign off = dcache_pkg::word_offset(entry.addr);

    always_comb begin
        base_line   = entry.miss ? refill_line : entry.hit_line;
        merged_line = base_line;
        for (int b = 0; b < 4; b++) begin
            if (entry.write && entry.byteen[b]) begin
                merged_line[off][8*b +: 8] = entry.wdata[8*b +: 8];
            end
        end
    end

    // move the addressed byte or halfword down to bit 0
    assign aligned = base_line[off] >> {entry.addr[1:0], 3'b000};

    always_comb begin
        case (entry.kind)
            dcache_pkg::LB:  resp_rdata = {{24{aligned[7]}}, aligned[7:0]};
            dcache_pkg::LBU: resp_rdata = {24'b0, aligned[7:0]};
            dcache_pkg::LH:  resp_rdata = {{16{aligned[15]}}, aligned[15:0]};
            dcache_pkg::LHU: resp_rdata = {16'b0, aligned[15:0]};
            default:         resp_rdata = aligned;    // lw
        endcase
    end

    assign resp_valid = entry.valid && !entry.write && !stall;

endmodule

`default_nettype wire

// File: rtl/dcache_top.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    input  logic                   req_write,
    input  dcache_pkg::word_t      req_addr,
    input  dcache_pkg::word_t      req_wdata,
    input  logic [3:0]             req_byteen,
    input  dcache_pkg::load_kind_t req_kind,
    output logic                   ready,
    output logic                   stall,
    output logic                   resp_valid,
    output dcache_pkg::word_t      resp_rdata,
    output logic                   ar_valid,
    input  logic                   ar_ready,
    output dcache_pkg::word_t      ar_addr,
    input  logic                   r_valid,
    output logic                   r_ready,
    input  dcache_pkg::word_t      r_data,
    input  logic                   r_last,
    output logic                   aw_valid,
    input  logic                   aw_ready,
    output dcache_pkg::word_t      aw_addr,
    output logic                   w_valid,
    input  logic                   w_ready,
    output dcache_pkg::word_t      w_data,
    output logic                   w_last,
    input  logic                   b_valid
);

    dcache_pkg::stage_entry_t entry;
    dcache_pkg::line_t        merged_line;
    dcache_pkg::line_t        refill_line;

    cache_wr_if wr_bus ();

    dcache_lookup lookup0 (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_write(req_write), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_byteen(req_byteen), .req_kind(req_kind),
        .stall(stall), .wr(wr_bus.ram), .entry(entry)
    );

    dcache_miss_ctrl miss_ctrl0 (
        .clk(clk), .rst(rst), .entry(entry), .merged_line(merged_line),
        .ready(ready), .stall(stall), .refill_line(refill_line), .wr(wr_bus.ctrl),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr),
        .r_valid(r_valid), .r_ready(r_ready), .r_data(r_data), .r_last(r_last),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw_addr(aw_addr),
        .w_valid(w_valid), .w_ready(w_ready), .w_data(w_data), .w_last(w_last),
        .b_valid(b_valid)
    );

    dcache_resp resp0 (
        .entry(entry), .refill_line(refill_line), .stall(stall),
        .merged_line(merged_line), .resp_valid(resp_valid), .resp_rdata(resp_rdata)
    );

endmodule

`default_nettype wire

// File: rtl/sdp_ram.sv
`timescale 1ns/100ps
`default_nettype none

module sdp_ram #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 8
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  payload_t                 wdata,
    input  logic                     ren,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output payload_t                 rdata
);

    payload_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, returns the old contents on a same-address write
    always_ff @(posedge clk) begin
        if (ren) begin
            rdata <= mem[raddr];
        end
    end

    a_waddr_known: assert property (@(posedge clk) we |-> !$isunknown(waddr));

endmodule

`default_nettype wire

// File: sim.f
rtl/dcache_pkg.sv
rtl/cache_wr_if.sv
rtl/sdp_ram.sv
rtl/dcache_lookup.sv
rtl/dcache_miss_ctrl.sv
rtl/dcache_resp.sv
rtl/dcache_top.sv
sim/axi_mem_model.sv
sim/tb_dcache.sv

// File: sim/axi_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

// burst memory behind the cache, ready and valid delays of 0 to 3 cycles
module axi_mem_model #(
    parameter int MEM_BYTES = 4096
) (
    input  logic              clk,
    input  logic              ar_valid,
    output logic              ar_ready,
    input  dcache_pkg::word_t ar_addr,
    output logic              r_valid,
    input  logic              r_ready,
    output dcache_pkg::word_t r_data,
    output logic              r_last,
    input  logic              aw_valid,
    output logic              aw_ready,
    input  dcache_pkg::word_t aw_addr,
    input  logic              w_valid,
    output logic              w_ready,
    input  dcache_pkg::word_t w_data,
    input  logic              w_last,
    output logic              b_valid,
    output int                wb_bursts,
    output int                rd_bursts,
    output dcache_pkg::word_t last_wb_addr,
    output logic              burst_error
);

    logic [7:0] mem [MEM_BYTES];
    logic [31:0] lcg_state;

    function automatic int next_delay();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[17:16]);
    endfunction

    function automatic dcache_pkg::word_t read_word(input int a);
        return {mem[a + 3], mem[a + 2], mem[a + 1], mem[a]};
    endfunction

    initial begin
        int ar_cnt, aw_cnt, w_cnt, r_cnt, b_cnt;
        int rd_beat, wr_beat, rd_base, wr_base;
        logic rd_active, b_pend;
        logic ar_fire, aw_fire, w_fire, r_fire, b_fire;
        dcache_pkg::word_t ar_addr_s, aw_addr_s, w_data_s, word;
        logic w_last_s;
        lcg_state = 32'h5f1a;
        for (int a = 0; a < MEM_BYTES; a += 4) begin
            word = dcache_pkg::word_t'(a) ^ 32'h5f1a0000;   // preload pattern
            for (int b = 0; b < 4; b++) mem[a + b] = word[8*b +: 8];
        end
        {ar_ready, r_valid, r_last, aw_ready, w_ready, b_valid, burst_error} = '0;
        r_data = '0;
        wb_bursts = 0;
        rd_bursts = 0;
        last_wb_addr = '0;
        rd_active = 1'b0;
        b_pend = 1'b0;
        rd_beat = 0;
        wr_beat = 0;
        rd_base = 0;
        wr_base = 0;
        b_cnt = 0;
        ar_cnt = next_delay();
        aw_cnt = next_delay();
        w_cnt = next_delay();
        r_cnt = next_delay();
        forever begin
            @(negedge clk);   // handshakes of the coming edge are stable here
            ar_fire = ar_valid && ar_ready;
            aw_fire = aw_valid && aw_ready;
            w_fire = w_valid && w_ready;
            r_fire = r_valid && r_ready;
            b_fire = b_valid;
            ar_addr_s = ar_addr;
            aw_addr_s = aw_addr;
            w_data_s = w_data;
            w_last_s = w_last;
            @(posedge clk);
            #1;
            if (ar_fire) begin
                if (ar_addr_s[3:0] != 4'h0) burst_error = 1'b1;
                rd_base = int'(ar_addr_s[11:0]);
                rd_beat = 0;
                rd_active = 1'b1;
                rd_bursts++;
                ar_cnt = next_delay();
                r_cnt = next_delay();
            end
            if (r_fire) begin
                rd_beat++;
                r_cnt = next_delay();
                if (rd_beat == dcache_pkg::LINE_WORDS) rd_active = 1'b0;
            end
            if (aw_fire) begin
                if (aw_addr_s[3:0] != 4'h0) burst_error = 1'b1;
                wr_base = int'(aw_addr_s[11:0]);
                last_wb_addr = aw_addr_s;
                wr_beat = 0;
                aw_cnt = next_delay();
            end
            if (w_fire) begin
                for (int b = 0; b < 4; b++) mem[wr_base + 4*wr_beat + b] = w_data_s[8*b +: 8];
                if (w_last_s != (wr_beat == dcache_pkg::LINE_WORDS - 1)) burst_error = 1'b1;
                wr_beat++;
                w_cnt = next_delay();
                if (wr_beat == dcache_pkg::LINE_WORDS) begin
                    wb_bursts++;
                    b_pend = 1'b1;
                    b_cnt = next_delay();
                end
            end
            if (b_fire) b_valid = 1'b0;
            if (b_pend) begin
                if (b_cnt > 0) begin
                    b_cnt--;
                end else begin
                    b_valid = 1'b1;
                    b_pend = 1'b0;
                end
            end
            if (ar_cnt > 0) ar_cnt--;
            if (aw_cnt > 0) aw_cnt--;
            if (w_cnt > 0) w_cnt--;
            if (rd_active && r_cnt > 0) r_cnt--;
            ar_ready = (ar_cnt == 0);
            aw_ready = (aw_cnt == 0);
            w_ready = (w_cnt == 0);
            r_valid = rd_active && (r_cnt == 0);
            r_data = read_word(rd_base + 4*(rd_beat % dcache_pkg::LINE_WORDS));
            r_last = (rd_beat == dcache_pkg::LINE_WORDS - 1);
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_dcache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dcache;

    localparam int MEM_BYTES    = 4096;
    localparam int READY_LIMIT  = dcache_pkg::SETS + 20;
    localparam int ACCEPT_LIMIT = 200;
    localparam int DRAIN_LIMIT  = 400;
    localparam int RANDOM_OPS   = 300;

    logic clk, rst;
    logic req_valid, req_write;
    dcache_pkg::word_t req_addr, req_wdata, resp_rdata;
    logic [3:0] req_byteen;
    dcache_pkg::load_kind_t req_kind;
    logic ready, stall, resp_valid;
    logic ar_valid, ar_ready, r_valid, r_ready, r_last;
    logic aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid;
    dcache_pkg::word_t ar_addr, r_data, aw_addr, w_data, last_wb_addr;
    int wb_bursts, rd_bursts;
    logic burst_error;

    logic [7:0] shadow [MEM_BYTES];   // what memory would hold without a cache
    logic [31:0] lcg_state;
    dcache_pkg::word_t exp_q[$];
    string name_q[$];
    string test_name;
    int cycle_cnt, accept_cycle, resp_cycle;
    logic stall_seen;

    dcache_top dut0 (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_write(req_write), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_byteen(req_byteen), .req_kind(req_kind),
        .ready(ready), .stall(stall), .resp_valid(resp_valid), .resp_rdata(resp_rdata),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr),
        .r_valid(r_valid), .r_ready(r_ready), .r_data(r_data), .r_last(r_last),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw_addr(aw_addr),
        .w_valid(w_valid), .w_ready(w_ready), .w_data(w_data), .w_last(w_last),
        .b_valid(b_valid)
    );

    axi_mem_model #(.MEM_BYTES(MEM_BYTES)) mem0 (
        .clk(clk),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr),
        .r_valid(r_valid), .r_ready(r_ready), .r_data(r_data), .r_last(r_last),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw_addr(aw_addr),
        .w_valid(w_valid), .w_ready(w_ready), .w_data(w_data), .w_last(w_last),
        .b_valid(b_valid), .wb_bursts(wb_bursts), .rd_bursts(rd_bursts),
        .last_wb_addr(last_wb_addr), .burst_error(burst_error)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial cycle_cnt = 0;
    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic fail_stop();
        $display("TB FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(input string name, input dcache_pkg::word_t expected,
                               input dcache_pkg::word_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %08h, actual %08h", name, expected, actual);
            fail_stop();
        end
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // expected load result built from the shadow bytes
    function automatic dcache_pkg::word_t ref_load(input dcache_pkg::load_kind_t kind,
                                                   input dcache_pkg::word_t addr);
        dcache_pkg::word_t w, s;
        int base;
        base = int'(addr[11:2]) * 4;
        w = {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
        s = w >> (8 * int'(addr[1:0]));
        case (kind)
            dcache_pkg::LB:  return {{24{s[7]}}, s[7:0]};
            dcache_pkg::LBU: return {24'h0, s[7:0]};
            dcache_pkg::LH:  return {{16{s[15]}}, s[15:0]};
            dcache_pkg::LHU: return {16'h0, s[15:0]};
            default:         return s;
        endcase
    endfunction

    task automatic shadow_store(input dcache_pkg::word_t addr, input dcache_pkg::word_t wdata,
                                input logic [3:0] byteen);
        int base;
        base = int'(addr[11:2]) * 4;
        for (int b = 0; b < 4; b++) begin
            if (byteen[b]) shadow[base + b] = wdata[8*b +: 8];
        end
    endtask

    // holds the request until it is taken and returns 10 ns after the taking edge
    task automatic issue(input logic write, input dcache_pkg::word_t addr,
                         input dcache_pkg::word_t wdata, input logic [3:0] byteen,
                         input dcache_pkg::load_kind_t kind);
        int waited;
        waited = 0;
        req_valid = 1'b1;
        req_write = write;
        req_addr = addr;
        req_wdata = wdata;
        req_byteen = byteen;
        req_kind = kind;
        @(negedge clk);
        while (!(ready && !stall)) begin
            waited++;
            if (waited > ACCEPT_LIMIT) begin
                $display("request to %08h was never accepted", addr);
                fail_stop();
            end
            @(negedge clk);
        end
        @(posedge clk);
        #10;
        accept_cycle = cycle_cnt;
        if (write) begin
            shadow_store(addr, wdata, byteen);
        end else begin
            exp_q.push_back(ref_load(kind, addr));
            name_q.push_back(test_name);
        end
        req_valid = 1'b0;
    endtask

    // quiet means no stall and nothing outstanding for a few cycles
    task automatic drain(input string what);
        int waited, quiet;
        waited = 0;
        quiet = 0;
        while (quiet < 4) begin
            @(negedge clk);
            if (stall || exp_q.size() != 0) quiet = 0;
            else quiet++;
            waited++;
            if (waited > DRAIN_LIMIT) begin
                $display("pipeline did not drain during %s", what);
                fail_stop();
            end
        end
        @(posedge clk);
        #10;
    endtask

    always @(negedge clk) begin   // compare process
        if (stall) stall_seen = 1'b1;
        if (resp_valid) begin
            if (exp_q.size() == 0) begin
                $display("load response with no load outstanding at cycle %0d", cycle_cnt);
                fail_stop();
            end else begin
                check_value(name_q.pop_front(), exp_q.pop_front(), resp_rdata);
                resp_cycle = cycle_cnt;
            end
        end
    end

    initial begin
        int waited, wb0, rd0;
        logic [31:0] r;
        dcache_pkg::word_t addr, word;
        {rst, req_valid, req_write, req_byteen} = {1'b1, 1'b0, 1'b0, 4'h0};
        req_addr = '0;
        req_wdata = '0;
        req_kind = dcache_pkg::LW;
        lcg_state = 32'h5f1a;
        resp_cycle = 0;
        stall_seen = 1'b0;
        for (int a = 0; a < MEM_BYTES; a += 4) begin
            word = dcache_pkg::word_t'(a) ^ 32'h5f1a0000;
            for (int b = 0; b < 4; b++) shadow[a + b] = word[8*b +: 8];
        end

        test_name = "reset";
        repeat (3) @(posedge clk);
        #10 rst = 1'b0;
        waited = 0;
        @(negedge clk);
        while (!ready) begin
            waited++;
            if (waited > READY_LIMIT) begin
                $display("ready did not rise after the reset sweep");
                fail_stop();
            end
            @(negedge clk);
        end
        check_value("reset idle outputs", 0, {27'h0, stall, ar_valid, aw_valid, w_valid, r_ready});
        @(posedge clk);
        #10;

        test_name = "miss_then_hit";
        rd0 = rd_bursts;
        issue(1'b0, 32'h0000_0018, '0, 4'h0, dcache_pkg::LW);
        drain(test_name);
        check_value("miss refill count", rd0 + 1, rd_bursts);
        stall_seen = 1'b0;
        issue(1'b0, 32'h0000_0014, '0, 4'h0, dcache_pkg::LW);
        waited = accept_cycle;
        drain(test_name);
        check_value("hit latency", 2, resp_cycle - waited);
        check_value("hit without stall", 0, stall_seen);

        test_name = "store_and_kinds";
        issue(1'b1, 32'h0000_0044, 32'ha1b2c3d4, 4'b0001, dcache_pkg::LW);
        issue(1'b1, 32'h0000_0048, 32'h8899aabb, 4'b1100, dcache_pkg::LW);
        issue(1'b1, 32'h0000_004c, 32'h00f07e80, 4'b0110, dcache_pkg::LW);
        issue(1'b1, 32'h0000_0040, 32'h12345678, 4'b1010, dcache_pkg::LW);
        for (int w = 0; w < 4; w++) begin
            for (int off = 0; off < 4; off++) begin
                for (int k = 0; k < 5; k++) begin
                    addr = 32'h0000_0040 + dcache_pkg::word_t'(4*w + off);
                    issue(1'b0, addr, '0, 4'h0, dcache_pkg::load_kind_t'(k));
                end
            end
        end
        drain(test_name);

        // three lines of set 0 where the first one written goes back to memory
        test_name = "evict";
        wb0 = wb_bursts;
        issue(1'b1, 32'h0000_0100, 32'hcafe0001, 4'b1111, dcache_pkg::LW);
        issue(1'b1, 32'h0000_0184, 32'hcafe0002, 4'b0011, dcache_pkg::LW);
        drain(test_name);
        issue(1'b1, 32'h0000_0208, 32'hcafe0003, 4'b1111, dcache_pkg::LW);
        drain(test_name);
        check_value("evict burst count", wb0 + 1, wb_bursts);
        check_value("evict burst address", 32'h0000_0100, last_wb_addr);
        check_value("evict burst shape", 0, burst_error);
        for (int a = 32'h100; a < 32'h110; a++) begin
            check_value("evict memory byte", shadow[a], mem0.mem[a]);
        end
        issue(1'b0, 32'h0000_0100, '0, 4'h0, dcache_pkg::LW);
        issue(1'b0, 32'h0000_0104, '0, 4'h0, dcache_pkg::LW);
        drain(test_name);

        test_name = "random";
        for (int i = 0; i < RANDOM_OPS; i++) begin
            r = next_rand();
            addr = dcache_pkg::word_t'(r[25:16]);
            if (r[27:26] == 2'b00) begin
                req_byteen = (r[31:28] == 4'h0) ? 4'hf : r[31:28];
                issue(1'b1, {addr[31:2], 2'b00}, next_rand(), req_byteen, dcache_pkg::LW);
            end else begin
                issue(1'b0, addr, '0, 4'h0, dcache_pkg::load_kind_t'(int'(r[30:28]) % 5));
            end
        end
        drain(test_name);
        check_value("random burst shape", 0, burst_error);

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
